// File: lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Word-wide SRAM. Only address bits 11:2 select a word, so higher addresses wrap.
  localparam int MEM_WORDS = 1024;
  localparam int MEM_AW = $clog2(MEM_WORDS);

  // Access width as used by loads, stores and the channel size fields.
  // The fourth code is unused and is handled as a word everywhere.
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_e;

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_EXEC = 1'b1
  } ls_state_e;

  // One request from the execute stage.
  // sext set means sign-extend the loaded field.
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    mem_size_e         size;
    logic              sext;
    logic              write;
    logic [DATA_W-1:0] wdata;
  } lsu_req_t;

  // Master side of the write address, write data and write response channels.
  typedef struct packed {
    logic              awvalid;
    logic [ADDR_W-1:0] awaddr;
    mem_size_e         awsize;
    logic              wvalid;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              bready;
  } axi_w_m2s_t;

  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
  } axi_w_s2m_t;

  // Master side of the read address and read data channels.
  typedef struct packed {
    logic              arvalid;
    logic [ADDR_W-1:0] araddr;
    mem_size_e         arsize;
    logic              rready;
  } axi_r_m2s_t;

  typedef struct packed {
    logic              arready;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } axi_r_s2m_t;

endpackage

`default_nettype wire

// File: store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align (
  input  wire logic [lsu_pkg::ADDR_W-1:0] addr,
  input  wire lsu_pkg::mem_size_e         size,
  input  wire logic [lsu_pkg::DATA_W-1:0] wdata,
  output logic [lsu_pkg::DATA_W-1:0]      wdata_lane,
  output logic [lsu_pkg::STRB_W-1:0]      wstrb
);

  import lsu_pkg::*;

  logic [1:0]        offset;
  logic [STRB_W-1:0] base_strb;

  assign offset = addr[1:0];

  always_comb begin
    case (size)
      SIZE_BYTE: base_strb = 4'b0001;
      SIZE_HALF: base_strb = 4'b0011;
      default:   base_strb = 4'b1111;
    endcase
  end

  // The low lanes of the store data move up to the addressed byte.
  assign wstrb      = base_strb << offset;
  assign wdata_lane = wdata << {offset, 3'b000};

  // A store never crosses the word, so the shifted strobe keeps every lane.
  always_comb begin
    if (!$isunknown({size, offset})) begin
      a_lane_fit : assert final (!(size == SIZE_HALF && offset == 2'd3) &&
                                 !(size != SIZE_BYTE && size != SIZE_HALF && offset != 2'd0))
        else $error("store_align: size %0d does not fit at offset %0d", size, offset);
    end
  end

endmodule

`default_nettype wire

// File: load_extract.sv
`timescale 1ns/1ps
`default_nettype none

module load_extract (
  input  wire logic [lsu_pkg::DATA_W-1:0] rdata,
  input  wire logic [1:0]                 offset,
  input  wire lsu_pkg::mem_size_e         size,
  input  wire logic                       sext,
  output logic [lsu_pkg::DATA_W-1:0]      value
);

  import lsu_pkg::*;

  logic [DATA_W-1:0] shifted;
  logic              byte_fill;
  logic              half_fill;

  // Bring the addressed byte down to lane 0.
  assign shifted = rdata >> {offset, 3'b000};

  // Top bit of the kept field, or zero for an unsigned load.
  assign byte_fill = sext & shifted[7];
  assign half_fill = sext & shifted[15];

  always_comb begin
    case (size)
      SIZE_BYTE: begin
        value = {{(DATA_W - 8){byte_fill}}, shifted[7:0]};
      end
      SIZE_HALF: begin
        value = {{(DATA_W - 16){half_fill}}, shifted[15:0]};
      end
      // Word, and the unused code, pass through whatever sext says.
      default: begin
        value = shifted;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: lsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl (
  input  wire logic                       clock,
  input  wire logic                       reset,
  input  wire lsu_pkg::lsu_req_t          req,
  input  wire logic                       req_valid,
  output logic                            req_ready,
  input  wire logic [lsu_pkg::DATA_W-1:0] wdata_lane,
  input  wire logic [lsu_pkg::STRB_W-1:0] wstrb,
  input  wire logic [lsu_pkg::DATA_W-1:0] load_value,
  output logic [1:0]                      ld_offset,
  output lsu_pkg::mem_size_e              ld_size,
  output logic                            ld_sext,
  output logic                            rsp_valid,
  output logic [lsu_pkg::DATA_W-1:0]      rsp_rdata,
  output lsu_pkg::axi_w_m2s_t             w_m2s,
  input  wire lsu_pkg::axi_w_s2m_t        w_s2m,
  output lsu_pkg::axi_r_m2s_t             r_m2s,
  input  wire lsu_pkg::axi_r_s2m_t        r_s2m
);

  import lsu_pkg::*;

  ls_state_e state;
  ls_state_e state_next;
  logic      accept;

  // Channel control.
  logic ar_valid_q;
  logic r_ready_q;
  logic aw_valid_q;
  logic w_valid_q;
  logic b_ready_q;

  // Channel payload captured on acceptance.
  logic [ADDR_W-1:0] ar_addr_q;
  mem_size_e         ar_size_q;
  logic              ar_sext_q;
  logic [ADDR_W-1:0] aw_addr_q;
  mem_size_e         aw_size_q;
  logic [DATA_W-1:0] w_data_q;
  logic [STRB_W-1:0] w_strb_q;

  assign accept = (state == ST_IDLE) && req_valid && req_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (accept) begin
          state_next = ST_EXEC;
        end
      end
      ST_EXEC: begin
        if (r_s2m.rvalid || w_s2m.bvalid) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  // Response strobes and the rready/bready acknowledges last a single cycle.
  always_ff @(posedge clock) begin
    if (reset) begin
      req_ready  <= 1'b1;
      rsp_valid  <= 1'b0;
      rsp_rdata  <= '0;
      ar_valid_q <= 1'b0;
      r_ready_q  <= 1'b0;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      b_ready_q  <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      r_ready_q <= 1'b0;
      b_ready_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            req_ready <= 1'b0;
            if (req.write) begin
              // A store is reported done to the core right away.
              aw_valid_q <= 1'b1;
              w_valid_q  <= 1'b1;
              rsp_valid  <= 1'b1;
            end else begin
              ar_valid_q <= 1'b1;
            end
          end
        end
        ST_EXEC: begin
          if (r_s2m.arready) begin
            ar_valid_q <= 1'b0;
          end
          if (w_s2m.awready) begin
            aw_valid_q <= 1'b0;
          end
          if (w_s2m.wready) begin
            w_valid_q <= 1'b0;
          end
          if (r_s2m.rvalid) begin
            r_ready_q <= 1'b1;
            rsp_valid <= 1'b1;
            rsp_rdata <= load_value;
            req_ready <= 1'b1;
          end
          if (w_s2m.bvalid) begin
            b_ready_q <= 1'b1;
            req_ready <= 1'b1;
          end
        end
        default: begin
          req_ready <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      if (req.write) begin
        aw_addr_q <= req.addr;
        aw_size_q <= req.size;
        w_data_q  <= wdata_lane;
        w_strb_q  <= wstrb;
      end else begin
        ar_addr_q <= req.addr;
        ar_size_q <= req.size;
        ar_sext_q <= req.sext;
      end
    end
  end

  always_comb begin
    w_m2s.awvalid = aw_valid_q;
    w_m2s.awaddr  = aw_addr_q;
    w_m2s.awsize  = aw_size_q;
    w_m2s.wvalid  = w_valid_q;
    w_m2s.wdata   = w_data_q;
    w_m2s.wstrb   = w_strb_q;
    w_m2s.bready  = b_ready_q;
    r_m2s.arvalid = ar_valid_q;
    r_m2s.araddr  = ar_addr_q;
    r_m2s.arsize  = ar_size_q;
    r_m2s.rready  = r_ready_q;
  end

  // The extractor works from the registered load address, not the live request.
  assign ld_offset = ar_addr_q[1:0];
  assign ld_size   = ar_size_q;
  assign ld_sext   = ar_sext_q;

  a_one_channel : assert property (@(posedge clock) disable iff (reset)
    !(r_m2s.arvalid && w_m2s.awvalid))
    else $error("lsu_ctrl: read and write address valid together");

  a_busy_not_ready : assert property (@(posedge clock) disable iff (reset)
    (state == ST_EXEC) |-> !req_ready)
    else $error("lsu_ctrl: req_ready high while a request is in flight");

endmodule

`default_nettype wire

// File: lsu_sram.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_sram (
  input  wire logic                clock,
  input  wire logic                reset,
  input  wire lsu_pkg::axi_w_m2s_t w_m2s,
  output lsu_pkg::axi_w_s2m_t      w_s2m,
  input  wire lsu_pkg::axi_r_m2s_t r_m2s,
  output lsu_pkg::axi_r_s2m_t      r_s2m
);

  import lsu_pkg::*;

  logic [DATA_W-1:0] mem [MEM_WORDS];

  logic              rvalid_q;
  logic              bvalid_q;
  logic [DATA_W-1:0] rdata_q;

  logic              write_ok;
  logic              read_go;
  logic [MEM_AW-1:0] w_idx;
  logic [MEM_AW-1:0] r_idx;

  // Address and data of a write are taken together in one transfer.
  assign write_ok = w_m2s.awvalid && w_m2s.wvalid && !bvalid_q;

  // A new read address is taken only when no read data is waiting.
  assign read_go = r_m2s.arvalid && !rvalid_q;

  assign w_idx = w_m2s.awaddr[MEM_AW+1:2];
  assign r_idx = r_m2s.araddr[MEM_AW+1:2];

  always_comb begin
    w_s2m.awready = write_ok;
    w_s2m.wready  = write_ok;
    w_s2m.bvalid  = bvalid_q;
    r_s2m.arready = !rvalid_q;
    r_s2m.rvalid  = rvalid_q;
    r_s2m.rdata   = rdata_q;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (read_go) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && r_m2s.rready) begin
        rvalid_q <= 1'b0;
      end
      if (write_ok) begin
        bvalid_q <= 1'b1;
      end else if (bvalid_q && w_m2s.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // Byte-masked write. Lanes without a strobe keep their old contents.
  always_ff @(posedge clock) begin
    if (write_ok) begin
      for (int lane = 0; lane < STRB_W; lane++) begin
        if (w_m2s.wstrb[lane]) begin
          mem[w_idx][lane*8 +: 8] <= w_m2s.wdata[lane*8 +: 8];
        end
      end
    end
  end

  // The whole word is returned and the master picks the lanes.
  always_ff @(posedge clock) begin
    if (read_go) begin
      rdata_q <= mem[r_idx];
    end
  end

  a_rvalid_hold : assert property (@(posedge clock) disable iff (reset)
    (r_s2m.rvalid && !r_m2s.rready) |=> (r_s2m.rvalid && $stable(r_s2m.rdata)))
    else $error("lsu_sram: read data dropped before rready");

endmodule

`default_nettype wire

// File: lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire lsu_pkg::lsu_req_t     req,
  input  wire logic                  req_valid,
  output logic                       req_ready,
  input  wire logic                  rsp_ready,
  output logic                       rsp_valid,
  output logic [lsu_pkg::DATA_W-1:0] rsp_rdata
);

  import lsu_pkg::*;

  // The core takes every response when it pulses, so rsp_ready is not used for flow control.

  logic [DATA_W-1:0] wdata_lane;
  logic [STRB_W-1:0] wstrb;
  logic [DATA_W-1:0] load_value;
  logic [1:0]        ld_offset;
  mem_size_e         ld_size;
  logic              ld_sext;

  axi_w_m2s_t w_m2s;
  axi_w_s2m_t w_s2m;
  axi_r_m2s_t r_m2s;
  axi_r_s2m_t r_s2m;

  store_align align_i (
    .addr       (req.addr),
    .size       (req.size),
    .wdata      (req.wdata),
    .wdata_lane (wdata_lane),
    .wstrb      (wstrb)
  );

  load_extract extract_i (
    .rdata  (r_s2m.rdata),
    .offset (ld_offset),
    .size   (ld_size),
    .sext   (ld_sext),
    .value  (load_value)
  );

  lsu_ctrl ctrl_i (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .wdata_lane (wdata_lane),
    .wstrb      (wstrb),
    .load_value (load_value),
    .ld_offset  (ld_offset),
    .ld_size    (ld_size),
    .ld_sext    (ld_sext),
    .rsp_valid  (rsp_valid),
    .rsp_rdata  (rsp_rdata),
    .w_m2s      (w_m2s),
    .w_s2m      (w_s2m),
    .r_m2s      (r_m2s),
    .r_s2m      (r_s2m)
  );

  lsu_sram sram_i (
    .clock (clock),
    .reset (reset),
    .w_m2s (w_m2s),
    .w_s2m (w_s2m),
    .r_m2s (r_m2s),
    .r_s2m (r_s2m)
  );

endmodule

`default_nettype wire

// File: tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;

  import lsu_pkg::*;

  logic              clock;
  logic              reset;
  lsu_req_t          req;
  logic              req_valid;
  logic              req_ready;
  logic              rsp_ready;
  logic              rsp_valid;
  logic [DATA_W-1:0] rsp_rdata;

  // Byte copy of the 4 KB window that the SRAM decodes.
  logic [7:0]  ref_mem [4096];
  logic [31:0] lcg_state = 32'd38801;

  lsu_top dut_i (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_ready (rsp_ready),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata)
  );

  always #10 clock = ~clock;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_run(string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_value(string test_name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      stop_run($sformatf("MISMATCH in %s: expected %h, actual %h", test_name, expected, actual));
    end
  endtask

  function automatic lsu_req_t make_req(logic [31:0] addr, mem_size_e size, logic sext,
                                        logic write, logic [31:0] data);
    lsu_req_t r;
    r.addr  = addr;
    r.size  = size;
    r.sext  = sext;
    r.write = write;
    r.wdata = data;
    return r;
  endfunction

  // Lanes come from the low bits of the store data; only the low 12 address bits count.
  task automatic model_store(logic [31:0] addr, mem_size_e size, logic [31:0] data);
    logic [11:0] a;
    a = addr[11:0];
    ref_mem[a] = data[7:0];
    if (size != SIZE_BYTE) begin
      ref_mem[a + 12'd1] = data[15:8];
    end
    if (size != SIZE_BYTE && size != SIZE_HALF) begin
      ref_mem[a + 12'd2] = data[23:16];
      ref_mem[a + 12'd3] = data[31:24];
    end
  endtask

  function automatic logic [31:0] expected_load(logic [31:0] addr, mem_size_e size, logic sext);
    logic [11:0] a;
    logic [11:0] w;
    logic [7:0]  b;
    logic [15:0] h;
    a = addr[11:0];
    w = {a[11:2], 2'b00};
    b = ref_mem[a];
    h = {ref_mem[a + 12'd1], ref_mem[a]};
    case (size)
      SIZE_BYTE: return {{24{sext & b[7]}}, b};
      SIZE_HALF: return {{16{sext & h[15]}}, h};
      default: begin
        return {ref_mem[w + 12'd3], ref_mem[w + 12'd2], ref_mem[w + 12'd1], ref_mem[w]};
      end
    endcase
  endfunction

  // Returns on the falling edge after the accepting edge, with req_valid still high.
  task automatic send_request(string test_name, lsu_req_t r, output int waited);
    req = r;
    req_valid = 1'b1;
    waited = 0;
    while (!req_ready) begin
      @(negedge clock);
      waited++;
      if (waited > 20) begin
        stop_run({test_name, ": the request was never accepted"});
      end
    end
    @(posedge clock);
    @(negedge clock);
  endtask

  task automatic wait_load_result(string test_name, logic [31:0] addr, mem_size_e size,
                                  logic sext);
    int cycles;
    cycles = 0;
    while (!rsp_valid) begin
      check_value({test_name, " req_ready while busy"}, 32'd0, {31'd0, req_ready});
      @(negedge clock);
      cycles++;
      if (cycles > 20) begin
        stop_run({test_name, ": no load response arrived"});
      end
    end
    check_value({test_name, " load latency"}, 32'd2, cycles);
    check_value({test_name, " load data"}, expected_load(addr, size, sext), rsp_rdata);
  endtask

  task automatic do_store(string test_name, logic [31:0] addr, mem_size_e size,
                          logic [31:0] data);
    int waited;
    send_request(test_name, make_req(addr, size, 1'b0, 1'b1, data), waited);
    req_valid = 1'b0;
    check_value({test_name, " store rsp_valid"}, 32'd1, {31'd0, rsp_valid});
    model_store(addr, size, data);
  endtask

  task automatic do_load(string test_name, logic [31:0] addr, mem_size_e size, logic sext);
    int waited;
    send_request(test_name, make_req(addr, size, sext, 1'b0, 32'd0), waited);
    req_valid = 1'b0;
    wait_load_result(test_name, addr, size, sext);
  endtask

  task automatic test_reset();
    check_value("reset req_ready", 32'd1, {31'd0, req_ready});
    check_value("reset rsp_valid", 32'd0, {31'd0, rsp_valid});
    check_value("reset rsp_rdata", 32'd0, rsp_rdata);
  endtask

  // Every word gets a known value that depends on its whole address.
  task automatic fill_memory();
    logic [31:0] addr;
    for (int i = 0; i < MEM_WORDS; i++) begin
      addr = i << 2;
      do_store("fill", addr, SIZE_WORD, (addr * 32'h9E3779B1) ^ 32'hC3A50F1E);
    end
  endtask

  task automatic test_words();
    logic [31:0] addrs [5];
    addrs = '{32'h0, 32'h4, 32'h7F0, 32'hFFC, 32'h1010};
    foreach (addrs[i]) begin
      do_store("word", addrs[i], SIZE_WORD, next_rand());
    end
    foreach (addrs[i]) begin
      do_load("word", addrs[i], SIZE_WORD, 1'b0);
    end
    // 0x1010 landed on the same word as 0x010.
    do_load("word wrap", 32'h10, SIZE_WORD, 1'b0);
    do_load("word wrap", 32'h2010, SIZE_WORD, 1'b1);
  endtask

  task automatic test_lanes();
    for (int off = 0; off < 4; off++) begin
      do_store("byte lanes", 32'h200 + off, SIZE_BYTE, next_rand());
      do_load("byte lanes", 32'h200, SIZE_WORD, 1'b0);
    end
    do_store("half lanes", 32'h244, SIZE_HALF, next_rand());
    do_load("half lanes", 32'h244, SIZE_WORD, 1'b0);
    do_store("half lanes", 32'h246, SIZE_HALF, next_rand());
    do_load("half lanes", 32'h244, SIZE_WORD, 1'b0);
  endtask

  task automatic test_extension();
    logic [31:0] words [2];
    words = '{32'hF08AC0FE, 32'h7F013C55};
    for (int w = 0; w < 2; w++) begin
      do_store("extension", 32'h300, SIZE_WORD, words[w]);
      for (int s = 0; s < 2; s++) begin
        for (int off = 0; off < 4; off++) begin
          do_load("extension byte", 32'h300 + off, SIZE_BYTE, s[0]);
          if (off % 2 == 0) begin
            do_load("extension half", 32'h300 + off, SIZE_HALF, s[0]);
          end
        end
      end
    end
  endtask

  task automatic test_timing();
    int waited;
    send_request("timing store", make_req(32'h500, SIZE_WORD, 1'b0, 1'b1, 32'hCAFEF00D), waited);
    model_store(32'h500, SIZE_WORD, 32'hCAFEF00D);
    check_value("timing store rsp_valid", 32'd1, {31'd0, rsp_valid});
    // A load is offered while the store is still in flight.
    req = make_req(32'h500, SIZE_WORD, 1'b0, 1'b0, 32'd0);
    @(negedge clock);
    check_value("timing store pulse", 32'd0, {31'd0, rsp_valid});
    check_value("timing store busy", 32'd0, {31'd0, req_ready});
    send_request("timing load", req, waited);
    check_value("timing load wait", 32'd1, waited);
    req = make_req(32'h502, SIZE_HALF, 1'b1, 1'b0, 32'd0);
    wait_load_result("timing load", 32'h500, SIZE_WORD, 1'b0);
    send_request("timing second load", req, waited);
    check_value("timing second load wait", 32'd0, waited);
    req_valid = 1'b0;
    wait_load_result("timing second load", 32'h502, SIZE_HALF, 1'b1);
  endtask

  task automatic test_random();
    logic [31:0] r;
    logic [31:0] addr;
    mem_size_e   size;
    for (int n = 0; n < 200; n++) begin
      r = next_rand();
      addr = {20'd0, r[27:16]};
      case (r[30:29])
        2'd0: begin
          size = SIZE_BYTE;
        end
        2'd1: begin
          size = SIZE_HALF;
          addr[0] = 1'b0;
        end
        default: begin
          size = SIZE_WORD;
          addr[1:0] = 2'b00;
        end
      endcase
      if (r[31]) begin
        do_store("random", addr, size, next_rand());
      end else begin
        do_load("random", addr, size, r[28]);
      end
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    req = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b1;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    test_reset();
    fill_memory();
    test_words();
    test_lanes();
    test_extension();
    test_timing();
    test_random();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: lsu_top.f
lsu_pkg.sv
store_align.sv
load_extract.sv
lsu_ctrl.sv
lsu_sram.sv
lsu_top.sv
tb_lsu_top.sv
